/* run_sim.sh */
#!/bin/sh
# Build with Verilator and run; pass only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_cim_top -f tb.f &&
./obj_dir/Vtb_cim_top | tee /dev/stderr | grep -qx "all tests passed" &&
echo "Simulation PASSED" ||
{ echo "Simulation FAILED"; exit 1; }

/* source/array_arbiter.sv */
// ####################################################################
// Array arbiter with Wishbone classic slave
// Grants the cell array to the host only while no MAC is using it
// ####################################################################

`timescale 1ns/1ps

module array_arbiter import cim_pkg::*, cim_bus_pkg::*; (
    input  logic        clk,
    input  logic        nrst,
    // Host port
    input  wb_req_t     wb_req_i,
    output wb_rsp_t     wb_rsp_o,
    // Sequencer status
    input  logic        mac_busy_i,
    input  logic        mac_start_i,
    // Array row port
    output array_acc_t  acc_o,
    input  weight_row_t rdata_i
);

    typedef enum logic {
        IDLE,
        ACK
    } arb_state_e;

    arb_state_e state_q;
    arb_state_e state_d;
    logic       host_req;
    logic       grant;

    assign host_req = wb_req_i.cyc && wb_req_i.stb;

    // MAC in flight or starting this cycle keeps the host waiting
    assign grant = (state_q == IDLE) && host_req && !mac_busy_i && !mac_start_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (grant) begin
                    state_d = ACK;
                end
            end
            ACK: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Exactly one array access per granted cycle
    assign acc_o.en    = grant;
    assign acc_o.we    = wb_req_i.we;
    assign acc_o.row   = wb_req_i.adr;
    assign acc_o.wdata = wb_req_i.dat;

    // Read data is registered in the array, valid in the ack cycle
    assign wb_rsp_o.ack = (state_q == ACK);
    assign wb_rsp_o.dat = rdata_i;

endmodule

/* source/cim_array_model.sv */
// ####################################################################
// CIM cell array model
// Binary weight cells, per-plane column sums with saturating ADCs,
// and a single row read/write port for the host side
// ####################################################################

`timescale 1ns/1ps

module cim_array_model import cim_pkg::*, cim_bus_pkg::*; #(
    parameter int NUM_ROWS = cim_pkg::NUM_ROWS,
    parameter int NUM_COLS = cim_pkg::NUM_COLS,
    parameter int ADC_BITS = cim_pkg::ADC_BITS
) (
    input  logic                       clk,
    input  logic                       nrst,
    // MAC side
    input  trit_plane_t                data_p_i,
    input  trit_plane_t                data_n_i,
    input  logic                       mac_en_i,
    output adc_code_t [NUM_COLS-1:0]   adc_out_o,
    // Row access side
    input  array_acc_t                 acc_i,
    output weight_row_t                rdata_o
);

    // Column sum spans -NUM_ROWS to +NUM_ROWS
    localparam int SUM_BITS = $clog2(NUM_ROWS) + 2;
    localparam logic signed [SUM_BITS-1:0] SUM_ONE = 1;
    localparam logic signed [SUM_BITS-1:0] SUM_HI  = SUM_BITS'((2 ** (ADC_BITS - 1)) - 1);
    localparam logic signed [SUM_BITS-1:0] SUM_LO  = SUM_BITS'(-(2 ** (ADC_BITS - 1)));

    weight_row_t [NUM_ROWS-1:0]  cells_q;
    logic signed [SUM_BITS-1:0]  col_sum [NUM_COLS];
    adc_code_t   [NUM_COLS-1:0]  adc_d;

    // Signed dot product of one plane against each column
    always_comb begin
        for (int c = 0; c < NUM_COLS; c++) begin
            col_sum[c] = '0;
            for (int r = 0; r < NUM_ROWS; r++) begin
                // Row contributes only when exactly one of p and n is set
                if (data_p_i[r] ^ data_n_i[r]) begin
                    if (data_p_i[r] == cells_q[r][c]) begin
                        col_sum[c] = col_sum[c] + SUM_ONE;
                    end else begin
                        col_sum[c] = col_sum[c] - SUM_ONE;
                    end
                end
            end
        end
    end

    // ADC clipping
    always_comb begin
        for (int c = 0; c < NUM_COLS; c++) begin
            if (col_sum[c] > SUM_HI) begin
                adc_d[c] = adc_code_t'(SUM_HI);
            end else if (col_sum[c] < SUM_LO) begin
                adc_d[c] = adc_code_t'(SUM_LO);
            end else begin
                adc_d[c] = adc_code_t'(col_sum[c]);
            end
        end
    end

    // Conversion result, one cycle after the plane
    always_ff @(posedge clk) begin
        if (mac_en_i) begin
            adc_out_o <= adc_d;
        end
    end

    // Weight cells, cleared to all -1
    always_ff @(posedge clk) begin
        if (!nrst) begin
            cells_q <= '0;
        end else if (acc_i.en && acc_i.we) begin
            cells_q[acc_i.row] <= acc_i.wdata;
        end
    end

    // Row readback
    always_ff @(posedge clk) begin
        if (acc_i.en && !acc_i.we) begin
            rdata_o <= cells_q[acc_i.row];
        end
    end

endmodule

/* source/cim_bus_pkg.sv */
// ####################################################################
// CIM bus package
// Wishbone request and response structs and the array access struct
// ####################################################################

package cim_bus_pkg;

    import cim_pkg::*;

    // Host to slave, classic cycle
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        row_addr_t   adr;
        weight_row_t dat;
    } wb_req_t;

    // Slave to host
    typedef struct packed {
        logic        ack;
        weight_row_t dat;
    } wb_rsp_t;

    // Single row access into the cell array
    typedef struct packed {
        logic        en;
        logic        we;
        row_addr_t   row;
        weight_row_t wdata;
    } array_acc_t;

endpackage

/* source/cim_pkg.sv */
// ####################################################################
// CIM datapath package
// Widths, sizing constants and typedefs for the matrix-vector engine
// ####################################################################

package cim_pkg;

    // Array geometry
    localparam int NUM_ROWS = 8;
    localparam int NUM_COLS = 4;

    // Input word and trit-plane sizing
    localparam int INPUT_BITS = 5;
    localparam int NUM_TRITS = INPUT_BITS - 1;

    // ADC code width per column
    localparam int ADC_BITS = 4;

    // Column result width, enough for the full shift-and-add range
    localparam int ACC_BITS = 8;

    localparam int ROW_ADDR_BITS = $clog2(NUM_ROWS);

    // One signed input element
    typedef logic signed [INPUT_BITS-1:0] input_word_t;

    // One magnitude bit per row for a single trit plane
    typedef logic [NUM_ROWS-1:0] trit_plane_t;

    // Saturated column sum, -8 to 7
    typedef logic signed [ADC_BITS-1:0] adc_code_t;

    // Final signed column result
    typedef logic signed [ACC_BITS-1:0] acc_word_t;

    // Weight bits of one row, 1 is +1 and 0 is -1
    typedef logic [NUM_COLS-1:0] weight_row_t;

    // Row index into the cell array
    typedef logic [ROW_ADDR_BITS-1:0] row_addr_t;

endpackage

/* source/cim_top.sv */
// ####################################################################
// CIM accelerator top level
// Host port, MAC sequencer, arbiter and cell array
// ####################################################################

`timescale 1ns/1ps

module cim_top import cim_pkg::*, cim_bus_pkg::*; #(
    parameter int NUM_ROWS   = cim_pkg::NUM_ROWS,
    parameter int NUM_COLS   = cim_pkg::NUM_COLS,
    parameter int INPUT_BITS = cim_pkg::INPUT_BITS,
    parameter int ADC_BITS   = cim_pkg::ADC_BITS
) (
    input  logic                       clk,
    input  logic                       nrst,
    // Host Wishbone port
    input  wb_req_t                    wb_req_i,
    output wb_rsp_t                    wb_rsp_o,
    // MAC port
    input  input_word_t [NUM_ROWS-1:0] mac_data_i,
    input  logic                       mac_valid_i,
    output logic                       ready_o,
    output logic                       valid_o,
    output acc_word_t   [NUM_COLS-1:0] mac_data_o
);

    trit_plane_t               data_p;
    trit_plane_t               data_n;
    logic                      mac_en;
    logic                      mac_start;
    adc_code_t  [NUM_COLS-1:0] adc_out;
    array_acc_t                array_acc;
    weight_row_t               row_rdata;

    seq_acc #(
        .NUM_ROWS   (NUM_ROWS),
        .NUM_COLS   (NUM_COLS),
        .INPUT_BITS (INPUT_BITS),
        .ADC_BITS   (ADC_BITS)
    ) u_seq_acc (
        .clk         (clk),
        .nrst        (nrst),
        .mac_data_i  (mac_data_i),
        .mac_valid_i (mac_valid_i),
        .ready_o     (ready_o),
        .valid_o     (valid_o),
        .mac_data_o  (mac_data_o),
        .data_p_o    (data_p),
        .data_n_o    (data_n),
        .mac_en_o    (mac_en),
        .mac_start_o (mac_start),
        .adc_out_i   (adc_out)
    );

    array_arbiter u_array_arbiter (
        .clk         (clk),
        .nrst        (nrst),
        .wb_req_i    (wb_req_i),
        .wb_rsp_o    (wb_rsp_o),
        .mac_busy_i  (mac_en),
        .mac_start_i (mac_start),
        .acc_o       (array_acc),
        .rdata_i     (row_rdata)
    );

    cim_array_model #(
        .NUM_ROWS (NUM_ROWS),
        .NUM_COLS (NUM_COLS),
        .ADC_BITS (ADC_BITS)
    ) u_cim_array_model (
        .clk       (clk),
        .nrst      (nrst),
        .data_p_i  (data_p),
        .data_n_i  (data_n),
        .mac_en_i  (mac_en),
        .adc_out_o (adc_out),
        .acc_i     (array_acc),
        .rdata_o   (row_rdata)
    );

endmodule

/* source/seq_acc.sv */
// ####################################################################
// Bit-serial MAC sequencer
// Feeds trit planes MSB first into the array and combines the ADC
// codes of each column by doubling and adding into a held result
// ####################################################################

`timescale 1ns/1ps

module seq_acc import cim_pkg::*; #(
    parameter int NUM_ROWS   = cim_pkg::NUM_ROWS,
    parameter int NUM_COLS   = cim_pkg::NUM_COLS,
    parameter int INPUT_BITS = cim_pkg::INPUT_BITS,
    parameter int ADC_BITS   = cim_pkg::ADC_BITS
) (
    input  logic                       clk,
    input  logic                       nrst,
    // MAC handshake
    input  input_word_t [NUM_ROWS-1:0] mac_data_i,
    input  logic                       mac_valid_i,
    output logic                       ready_o,
    output logic                       valid_o,
    output acc_word_t   [NUM_COLS-1:0] mac_data_o,
    // Array side
    output trit_plane_t                data_p_o,
    output trit_plane_t                data_n_o,
    output logic                       mac_en_o,
    output logic                       mac_start_o,
    input  adc_code_t   [NUM_COLS-1:0] adc_out_i
);

    localparam int TRITS    = INPUT_BITS - 1;
    localparam int STAGES   = TRITS + 2;
    localparam int ACC_BITS = $bits(acc_word_t);

    trit_plane_t [TRITS-1:0]    pos_planes;
    trit_plane_t [TRITS-1:0]    neg_planes;
    trit_plane_t [TRITS-1:0]    pos_q;
    trit_plane_t [TRITS-1:0]    neg_q;
    logic        [STAGES-1:0]   tracker_q;
    acc_word_t   [NUM_COLS-1:0] acc_q;
    acc_word_t   [NUM_COLS-1:0] adc_ext;
    acc_word_t   [NUM_COLS-1:0] acc_step;
    logic                       accept;

    twos_to_bipolar #(
        .NUM_LANES (NUM_ROWS),
        .IN_BITS   (INPUT_BITS)
    ) u_twos_to_bipolar (
        .twos_i (mac_data_i),
        .pos_o  (pos_planes),
        .neg_o  (neg_planes)
    );

    assign accept      = mac_valid_i && ready_o;
    assign mac_start_o = accept;

    // Tracker bit k marks an item k+1 edges past acceptance
    always_ff @(posedge clk) begin
        if (!nrst) begin
            tracker_q <= '0;
        end else begin
            tracker_q <= {tracker_q[STAGES-2:0], accept};
        end
    end

    // Planes leave from the top, MSB plane first
    always_ff @(posedge clk) begin
        if (accept) begin
            pos_q <= pos_planes;
            neg_q <= neg_planes;
        end else begin
            pos_q <= {pos_q[TRITS-2:0], trit_plane_t'('0)};
            neg_q <= {neg_q[TRITS-2:0], trit_plane_t'('0)};
        end
    end

    assign data_p_o = pos_q[TRITS-1];
    assign data_n_o = neg_q[TRITS-1];

    // Busy on the array while any plane is still being applied
    assign mac_en_o = |tracker_q[TRITS-1:0];
    assign ready_o  = ~|tracker_q[TRITS-2:0];
    assign valid_o  = tracker_q[STAGES-1];

    always_comb begin
        for (int c = 0; c < NUM_COLS; c++) begin
            adc_ext[c]  = {{(ACC_BITS - ADC_BITS){adc_out_i[c][ADC_BITS-1]}}, adc_out_i[c]};
            acc_step[c] = (acc_q[c] <<< 1) + adc_ext[c];
        end
    end

    // First code loads, middle codes double and add
    always_ff @(posedge clk) begin
        if (tracker_q[1]) begin
            acc_q <= adc_ext;
        end else if (|tracker_q[TRITS-1:2]) begin
            acc_q <= acc_step;
        end
    end

    // Last plane lands straight in the result register
    always_ff @(posedge clk) begin
        if (!nrst) begin
            mac_data_o <= '0;
        end else if (tracker_q[TRITS]) begin
            mac_data_o <= acc_step;
        end
    end

endmodule

/* source/twos_to_bipolar.sv */
// ####################################################################
// Two's complement to bipolar trit planes
// Splits each signed word into positive and negative magnitude planes
// ####################################################################

`timescale 1ns/1ps

module twos_to_bipolar import cim_pkg::*; #(
    parameter int NUM_LANES = cim_pkg::NUM_ROWS,
    parameter int IN_BITS   = cim_pkg::INPUT_BITS
) (
    input  input_word_t [NUM_LANES-1:0] twos_i,
    output trit_plane_t [IN_BITS-2:0]   pos_o,
    output trit_plane_t [IN_BITS-2:0]   neg_o
);

    localparam int MAG_BITS = IN_BITS - 1;

    always_comb begin
        logic [IN_BITS-1:0]  abs_val;
        logic [MAG_BITS-1:0] mag;
        logic                sign;

        pos_o = '0;
        neg_o = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            sign    = twos_i[l][IN_BITS-1];
            abs_val = sign ? -twos_i[l] : twos_i[l];
            // Most negative word has no room in MAG_BITS, clamp it
            mag = abs_val[IN_BITS-1] ? '1 : abs_val[MAG_BITS-1:0];
            for (int k = 0; k < MAG_BITS; k++) begin
                pos_o[k][l] = !sign && mag[k];
                neg_o[k][l] = sign && mag[k];
            end
        end
    end

endmodule

/* tb.f */
source/cim_pkg.sv
source/cim_bus_pkg.sv
source/twos_to_bipolar.sv
source/cim_array_model.sv
source/array_arbiter.sv
source/seq_acc.sv
source/cim_top.sv
verification/cim_assert.sv
verification/tb_cim_top.sv

/* verification/cim_assert.sv */
// ####################################################################
// Handshake and arbitration assertions for the CIM top level
// ####################################################################

`timescale 1ns/1ps

module cim_assert (
    input logic clk,
    input logic nrst,
    input logic mac_valid_i,
    input logic ready_i,
    input logic valid_i,
    input logic ack_i,
    input logic mac_en_i
);

    logic accept;
    int   fail_count = 0;

    assign accept = mac_valid_i && ready_i;

    ack_one_cycle: assert property (@(posedge clk) disable iff (!nrst) ack_i |=> !ack_i)
        else begin
            fail_count = fail_count + 1;
            $error("Wishbone ack held for two cycles");
        end

    // Acceptance edge plus five edges
    valid_latency: assert property (@(posedge clk) disable iff (!nrst)
        valid_i == $past(accept, 6))
        else begin
            fail_count = fail_count + 1;
            $error("valid_o not exactly five cycles after acceptance");
        end

    ack_not_busy: assert property (@(posedge clk) disable iff (!nrst) !(ack_i && mac_en_i))
        else begin
            fail_count = fail_count + 1;
            $error("Wishbone ack while the MAC holds the array");
        end

    ready_gap: assert property (@(posedge clk) disable iff (!nrst)
        ($past(accept, 1) || $past(accept, 2) || $past(accept, 3)) |-> !ready_i)
        else begin
            fail_count = fail_count + 1;
            $error("ready_o high within three cycles of acceptance");
        end

endmodule

/* verification/tb_cim_top.sv */
// ####################################################################
// Testbench for the CIM accelerator top level
// Directed tests checked against a reference model of the MAC rule
// ####################################################################

`timescale 1ns/1ps

module tb_cim_top import cim_pkg::*, cim_bus_pkg::*; ();

    localparam int TIMEOUT = 40;
    localparam int MAG_MAX = (2 ** (INPUT_BITS - 1)) - 1;
    localparam int ADC_MAX = (2 ** (ADC_BITS - 1)) - 1;
    localparam int ADC_MIN = -(2 ** (ADC_BITS - 1));

    typedef input_word_t [NUM_ROWS-1:0] vec_t;
    typedef acc_word_t   [NUM_COLS-1:0] result_t;

    logic        clk;
    logic        nrst;
    wb_req_t     wb_req_i;
    wb_rsp_t     wb_rsp_o;
    vec_t        mac_data_i;
    logic        mac_valid_i;
    logic        ready_o;
    logic        valid_o;
    result_t     mac_data_o;
    logic [31:0] lcg_state = 32'h8e26095a;
    int          cyc_cnt = 0;
    weight_row_t shadow_w [NUM_ROWS];
    result_t     exp_q [$];
    int          due_q [$];

    cim_top #(
        .NUM_ROWS   (NUM_ROWS),
        .NUM_COLS   (NUM_COLS),
        .INPUT_BITS (INPUT_BITS),
        .ADC_BITS   (ADC_BITS)
    ) u_dut (
        .clk         (clk),
        .nrst        (nrst),
        .wb_req_i    (wb_req_i),
        .wb_rsp_o    (wb_rsp_o),
        .mac_data_i  (mac_data_i),
        .mac_valid_i (mac_valid_i),
        .ready_o     (ready_o),
        .valid_o     (valid_o),
        .mac_data_o  (mac_data_o)
    );

    bind cim_top cim_assert u_cim_assert (
        .clk         (clk),
        .nrst        (nrst),
        .mac_valid_i (mac_valid_i),
        .ready_i     (ready_o),
        .valid_i     (valid_o),
        .ack_i       (wb_rsp_o.ack),
        .mac_en_i    (mac_en)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
    end

    task automatic end_with_failure();
        $display("tests failed");
        $fatal(1, "Stopped at first failure");
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_row(string name, weight_row_t got, weight_row_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_acc(string name, acc_word_t got, acc_word_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            end_with_failure();
        end
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic vec_t rand_vec(logic neg_only);
        vec_t        v;
        logic [31:0] r;
        for (int i = 0; i < NUM_ROWS; i++) begin
            r = next_rand();
            v[i] = input_word_t'(r[20:16]);
            if (neg_only) begin
                v[i][INPUT_BITS-1] = 1'b1;
            end
        end
        return v;
    endfunction

    // Trit planes MSB first, clipped column sums, then doubling
    function automatic result_t ref_mac(vec_t vec);
        result_t     res;
        input_word_t w;
        int          acc;
        int          sum;
        int          mag;
        int          trit;
        for (int c = 0; c < NUM_COLS; c++) begin
            acc = 0;
            for (int k = NUM_TRITS - 1; k >= 0; k--) begin
                sum = 0;
                for (int r = 0; r < NUM_ROWS; r++) begin
                    w = vec[r];
                    mag = (w < 0) ? -int'(w) : int'(w);
                    mag = (mag > MAG_MAX) ? MAG_MAX : mag;
                    trit = (w < 0) ? -((mag >> k) & 1) : ((mag >> k) & 1);
                    sum += shadow_w[r][c] ? trit : -trit;
                end
                sum = (sum > ADC_MAX) ? ADC_MAX : ((sum < ADC_MIN) ? ADC_MIN : sum);
                acc = 2 * acc + sum;
            end
            res[c] = acc_word_t'(acc);
        end
        return res;
    endfunction

    // Each result is due five edges after its acceptance edge
    always @(negedge clk) begin
        if (nrst) begin
            if (due_q.size() != 0 && due_q[0] == cyc_cnt) begin
                check_bit("valid_o", valid_o, 1'b1);
                for (int c = 0; c < NUM_COLS; c++) begin
                    check_acc($sformatf("mac_data_o[%0d]", c), mac_data_o[c], exp_q[0][c]);
                end
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
            end else begin
                check_bit("valid_o", valid_o, 1'b0);
            end
        end
    end

    task automatic wb_access(input logic we, input row_addr_t adr, input weight_row_t wdat,
                             output weight_row_t rdat, output logic waited);
        wb_req_t req;
        int      cnt;
        req     = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        cnt     = 0;
        @(posedge clk);
        wb_req_i <= req;
        @(negedge clk);
        while (!wb_rsp_o.ack) begin
            cnt++;
            if (cnt > TIMEOUT) begin
                $display("Timeout: Wishbone access to row %0d never acknowledged", adr);
                end_with_failure();
            end
            @(negedge clk);
        end
        // Held off when the ack came later than on an idle array
        waited = (cnt > 1);
        check_bit("mac_en", u_dut.mac_en, 1'b0);
        rdat = wb_rsp_o.dat;
        @(posedge clk);
        wb_req_i <= '0;
    endtask

    task automatic wb_write(row_addr_t adr, weight_row_t dat);
        weight_row_t rdat;
        logic        waited;
        wb_access(1'b1, adr, dat, rdat, waited);
        shadow_w[adr] = dat;
    endtask

    task automatic load_weights(logic rand_en, weight_row_t fill);
        logic [31:0] r;
        for (int i = 0; i < NUM_ROWS; i++) begin
            r = next_rand();
            wb_write(row_addr_t'(i), rand_en ? r[NUM_COLS-1:0] : fill);
        end
    endtask

    // Holds valid until the accepting edge, then records the expected result
    task automatic send_mac(vec_t vec);
        int cnt;
        cnt = 0;
        @(posedge clk);
        mac_data_i  <= vec;
        mac_valid_i <= 1'b1;
        @(negedge clk);
        while (!ready_o) begin
            cnt++;
            if (cnt > TIMEOUT) begin
                $display("Timeout: MAC input never accepted");
                end_with_failure();
            end
            @(negedge clk);
        end
        exp_q.push_back(ref_mac(vec));
        due_q.push_back(cyc_cnt + 6);
        @(posedge clk);
        mac_valid_i <= 1'b0;
    endtask

    task automatic wait_results();
        int cnt;
        cnt = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            cnt++;
            if (cnt > TIMEOUT) begin
                $display("Timeout: MAC results still outstanding");
                end_with_failure();
            end
        end
    endtask

    task automatic reset_values();
        @(negedge clk);
        check_bit("ready_o", ready_o, 1'b1);
        check_bit("valid_o", valid_o, 1'b0);
        check_bit("wb_rsp_o.ack", wb_rsp_o.ack, 1'b0);
        for (int c = 0; c < NUM_COLS; c++) begin
            check_acc($sformatf("mac_data_o[%0d]", c), mac_data_o[c], '0);
        end
    endtask

    task automatic row_readback();
        weight_row_t rdat;
        logic        waited;
        load_weights(1'b1, '0);
        for (int i = 0; i < NUM_ROWS; i++) begin
            wb_access(1'b0, row_addr_t'(i), '0, rdat, waited);
            check_row($sformatf("wb_rsp_o.dat row %0d", i), rdat, shadow_w[i]);
        end
    endtask

    task automatic single_mac();
        load_weights(1'b1, '0);
        repeat (4) begin
            send_mac(rand_vec(1'b0));
            wait_results();
        end
        // Full-scale inputs drive every ADC to its upper clip and to its lowest code
        load_weights(1'b0, '1);
        send_mac({NUM_ROWS{input_word_t'(MAG_MAX)}});
        wait_results();
        load_weights(1'b0, '0);
        send_mac({NUM_ROWS{input_word_t'(MAG_MAX)}});
        wait_results();
    endtask

    task automatic back_to_back_macs();
        load_weights(1'b1, '0);
        repeat (6) begin
            send_mac(rand_vec(1'b0));
        end
        wait_results();
    endtask

    task automatic host_during_mac();
        weight_row_t new_row;
        weight_row_t rdat;
        logic        waited;
        load_weights(1'b1, '0);
        new_row = ~shadow_w[3];
        send_mac(rand_vec(1'b0));
        wb_access(1'b1, row_addr_t'(3), new_row, rdat, waited);
        shadow_w[3] = new_row;
        check_bit("host access held off by MAC", waited, 1'b1);
        wait_results();
        wb_access(1'b0, row_addr_t'(3), '0, rdat, waited);
        check_row("wb_rsp_o.dat row 3", rdat, new_row);
    endtask

    task automatic negative_inputs();
        load_weights(1'b1, '0);
        send_mac({NUM_ROWS{input_word_t'(-(MAG_MAX + 1))}});
        wait_results();
        repeat (3) begin
            send_mac(rand_vec(1'b1));
            wait_results();
        end
    endtask

    initial begin
        nrst        = 1'b0;
        wb_req_i    = '0;
        mac_data_i  = '0;
        mac_valid_i = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            shadow_w[i] = '0;
        end
        repeat (3) @(posedge clk);
        nrst <= 1'b1;
        reset_values();
        row_readback();
        single_mac();
        back_to_back_macs();
        host_during_mac();
        negative_inputs();
        repeat (4) @(posedge clk);
        if (u_dut.u_cim_assert.fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
